// ==== list.f ====
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/inst_field_decoder.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/issue_control.sv
verilog/issue_register.sv
verilog/issue_stage.sv
bench/issue_stage_checker.sv
bench/issue_stage_tb.sv

// ==== bench/issue_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage_tb;

    localparam int NUM_ROWS = 16;
    localparam int PERIOD   = 40;

    logic                   clk;
    logic                   reset;
    rename_pkg::lane_mask_t in_valid_i;
    rename_pkg::instr_t     instr0_i;
    rename_pkg::instr_t     instr1_i;
    rename_pkg::addr_t      pc0_i;
    rename_pkg::addr_t      pc1_i;
    logic                   in_ready_o;
    logic                   flush_i;
    rename_pkg::lane_mask_t commit_valid_i;
    rename_pkg::phys_reg_t  commit_phys0_i;
    rename_pkg::phys_reg_t  commit_phys1_i;
    logic                   dispatch_ready_i;
    rename_pkg::lane_mask_t issue_valid_o;
    rename_pkg::addr_t      issue_pc0_o;
    rename_pkg::addr_t      issue_pc1_o;
    rename_pkg::phys_reg_t  rs1_phys0_o;
    rename_pkg::phys_reg_t  rs2_phys0_o;
    rename_pkg::phys_reg_t  rd_phys0_o;
    rename_pkg::phys_reg_t  old_rd_phys0_o;
    rename_pkg::phys_reg_t  rs1_phys1_o;
    rename_pkg::phys_reg_t  rs2_phys1_o;
    rename_pkg::phys_reg_t  rd_phys1_o;
    rename_pkg::phys_reg_t  old_rd_phys1_o;
    rename_pkg::lane_mask_t writes_rd_o;

    // Stimulus table, one row per cycle, with the expected in_ready_o
    logic [1:0] t_valid [NUM_ROWS];
    logic [31:0] t_ins0 [NUM_ROWS];
    logic [31:0] t_ins1 [NUM_ROWS];
    logic [31:0] t_pc0 [NUM_ROWS];
    logic [31:0] t_pc1 [NUM_ROWS];
    logic t_dr [NUM_ROWS];
    logic t_fl [NUM_ROWS];
    logic [1:0] t_cv [NUM_ROWS];
    int t_c0 [NUM_ROWS];
    int t_c1 [NUM_ROWS];
    logic t_rdy [NUM_ROWS];
    int n_rows = 0;

    // Reference rename state and the expected output register
    int map_ref [32];
    int free_q [$];
    logic [1:0] exp_valid;
    logic [1:0] exp_wr;
    int exp_pc [2];
    int exp_rs1 [2];
    int exp_rs2 [2];
    int exp_rd [2];
    int exp_old [2];
    int errors = 0;

    issue_stage #(.PHYS_REGS(40)) issue_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Bounded by the table length plus some spare cycles
    initial begin
        #((NUM_ROWS + 10) * PERIOD);
        $display("Timeout: the test table did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

    // ======================================================================
    // Instruction encoders
    // ======================================================================
    function automatic logic [31:0] r_op(input int rd, input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_op(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    // Store and branch carry immediate bits in the rd field
    function automatic logic [31:0] sw_op(input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'b010, 5'd4, 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_op(input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'b000, 5'd8, 7'b1100011};
    endfunction

    task automatic add_row(input logic [1:0] v, input logic [31:0] i0, input logic [31:0] i1,
                           input logic dr, input logic fl, input logic [1:0] cv,
                           input int c0, input int c1, input logic rdy);
        t_valid[n_rows] = v;
        t_ins0[n_rows]  = i0;
        t_ins1[n_rows]  = i1;
        t_pc0[n_rows]   = 32'h1000 + n_rows * 8;
        t_pc1[n_rows]   = 32'h1004 + n_rows * 8;
        t_dr[n_rows]    = dr;
        t_fl[n_rows]    = fl;
        t_cv[n_rows]    = cv;
        t_c0[n_rows]    = c0;
        t_c1[n_rows]    = c1;
        t_rdy[n_rows]   = rdy;
        n_rows++;
    endtask

    // ======================================================================
    // Test table
    // ======================================================================
    task automatic build_table();
        // Identity sources, rd takes 32 and 33
        add_row(2'b11, r_op(1, 2, 3), r_op(4, 5, 6), 1, 0, 2'b00, 0, 0, 1);
        // Forwarded source and same rd in both lanes
        add_row(2'b11, r_op(7, 1, 4), r_op(7, 7, 1), 1, 0, 2'b00, 0, 0, 1);
        // Store and addi to x0, then a branch with lane 1 idle
        add_row(2'b11, sw_op(4, 1), addi_op(0, 7, 1), 1, 0, 2'b00, 0, 0, 1);
        add_row(2'b01, beq_op(7, 1), 32'h0, 1, 0, 2'b00, 0, 0, 1);
        // Two cycles of back-pressure, then a flush
        add_row(2'b11, r_op(2, 1, 1), r_op(3, 2, 2), 0, 0, 2'b00, 0, 0, 0);
        add_row(2'b11, r_op(2, 1, 1), r_op(3, 2, 2), 0, 0, 2'b00, 0, 0, 0);
        add_row(2'b11, r_op(2, 1, 1), r_op(3, 2, 2), 1, 1, 2'b00, 0, 0, 0);
        add_row(2'b11, r_op(2, 1, 1), r_op(3, 2, 2), 1, 0, 2'b00, 0, 0, 1);
        // Last two free entries, then the list is empty
        add_row(2'b11, r_op(5, 7, 2), r_op(6, 5, 3), 1, 0, 2'b00, 0, 0, 1);
        add_row(2'b11, r_op(8, 1, 1), r_op(9, 1, 1), 1, 0, 2'b11, 1, 4, 0);
        // Returned registers come back in tail order
        add_row(2'b11, r_op(8, 1, 2), r_op(9, 8, 0), 1, 0, 2'b01, 7, 0, 1);
        add_row(2'b01, r_op(10, 8, 8), 32'h0, 1, 0, 2'b11, 2, 3, 0);
        add_row(2'b11, r_op(10, 8, 9), r_op(11, 10, 10), 1, 0, 2'b00, 0, 0, 1);
        add_row(2'b00, 32'h0, 32'h0, 1, 0, 2'b10, 0, 5, 0);
        // Lane 1 alone takes the head entry
        add_row(2'b10, 32'h0, r_op(12, 11, 0), 1, 0, 2'b00, 0, 0, 1);
        add_row(2'b00, 32'h0, 32'h0, 1, 0, 2'b00, 0, 0, 0);
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic logic writes_ref(input logic v, input logic [31:0] ins);
        logic cls;
        case (ins[6:0])
            7'b0110011, 7'b0010011, 7'b0000011, 7'b0110111,
            7'b0010111, 7'b1101111, 7'b1100111: cls = 1'b1;
            default: cls = 1'b0;
        endcase
        return v && cls && (ins[11:7] != 5'd0);
    endfunction

    task automatic model_step(input int r);
        logic acc;
        logic w0;
        logic w1;
        int n0;
        int n1;
        int rd0;
        int rd1;
        // Acceptance needs dispatch ready, no flush and two free entries
        acc = t_dr[r] && !t_fl[r] && (free_q.size() >= 2) && (t_valid[r] != 2'b00);
        w0  = writes_ref(t_valid[r][0], t_ins0[r]);
        w1  = writes_ref(t_valid[r][1], t_ins1[r]);
        rd0 = t_ins0[r][11:7];
        rd1 = t_ins1[r][11:7];
        n0  = (acc && w0) ? free_q[0] : 0;
        n1  = (acc && w1) ? (w0 ? free_q[1] : free_q[0]) : 0;
        if (t_fl[r]) begin
            exp_valid = 2'b00;
            exp_wr    = 2'b00;
        end else if (t_dr[r]) begin
            exp_valid = acc ? t_valid[r] : 2'b00;
            exp_wr    = acc ? {w1, w0} : 2'b00;
            exp_pc[0]  = t_pc0[r];
            exp_pc[1]  = t_pc1[r];
            exp_rs1[0] = map_ref[t_ins0[r][19:15]];
            exp_rs2[0] = map_ref[t_ins0[r][24:20]];
            exp_rd[0]  = n0;
            exp_old[0] = w0 ? map_ref[rd0] : 0;
            // Lane 1 sees lane 0's new mapping
            exp_rs1[1] = (w0 && t_ins1[r][19:15] == rd0) ? n0 : map_ref[t_ins1[r][19:15]];
            exp_rs2[1] = (w0 && t_ins1[r][24:20] == rd0) ? n0 : map_ref[t_ins1[r][24:20]];
            exp_rd[1]  = n1;
            exp_old[1] = !w1 ? 0 : (w0 && rd1 == rd0) ? n0 : map_ref[rd1];
        end
        if (acc && w0) begin
            map_ref[rd0] = n0;
            void'(free_q.pop_front());
        end
        if (acc && w1) begin
            map_ref[rd1] = n1;
            void'(free_q.pop_front());
        end
        if (t_cv[r][0]) free_q.push_back(t_c0[r]);
        if (t_cv[r][1]) free_q.push_back(t_c1[r]);
    endtask

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        int got [2][5];
        got[0] = '{issue_pc0_o, rs1_phys0_o, rs2_phys0_o, rd_phys0_o, old_rd_phys0_o};
        got[1] = '{issue_pc1_o, rs1_phys1_o, rs2_phys1_o, rd_phys1_o, old_rd_phys1_o};
        check_value("issue_valid_o", issue_valid_o, exp_valid);
        check_value("writes_rd_o", writes_rd_o, exp_wr);
        for (int l = 0; l < 2; l++) begin
            // Payload only means something on a valid lane
            if (exp_valid[l]) begin
                check_value($sformatf("pc lane %0d", l), got[l][0], exp_pc[l]);
                check_value($sformatf("rs1_phys lane %0d", l), got[l][1], exp_rs1[l]);
                check_value($sformatf("rs2_phys lane %0d", l), got[l][2], exp_rs2[l]);
                check_value($sformatf("rd_phys lane %0d", l), got[l][3], exp_rd[l]);
                check_value($sformatf("old_rd_phys lane %0d", l), got[l][4], exp_old[l]);
            end
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        reset            = 1'b0;
        in_valid_i       = '0;
        instr0_i         = '0;
        instr1_i         = '0;
        pc0_i            = '0;
        pc1_i            = '0;
        flush_i          = 1'b0;
        commit_valid_i   = '0;
        commit_phys0_i   = '0;
        commit_phys1_i   = '0;
        dispatch_ready_i = 1'b1;
        exp_valid        = 2'b00;
        exp_wr           = 2'b00;
        build_table();
        for (int a = 0; a < 32; a++) map_ref[a] = a;
        for (int p = 32; p < 40; p++) free_q.push_back(p);
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b1;
        #5;
        check_value("issue_valid_o after reset", issue_valid_o, 0);
        check_value("in_ready_o after reset", in_ready_o, 1);
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #1;
            check_outputs();
            #1;
            in_valid_i       = t_valid[r];
            instr0_i         = t_ins0[r];
            instr1_i         = t_ins1[r];
            pc0_i            = t_pc0[r];
            pc1_i            = t_pc1[r];
            dispatch_ready_i = t_dr[r];
            flush_i          = t_fl[r];
            commit_valid_i   = t_cv[r];
            commit_phys0_i   = rename_pkg::phys_reg_t'(t_c0[r]);
            commit_phys1_i   = rename_pkg::phys_reg_t'(t_c1[r]);
            #5;
            check_value($sformatf("in_ready_o row %0d", r), in_ready_o, t_rdy[r]);
            model_step(r);
        end
        @(posedge clk);
        #1;
        check_outputs();
        $display("Errors: %0d check(s), %0d assertion(s)", errors,
                 issue_stage_i.chk_i.assert_fails);
        if (errors == 0 && issue_stage_i.chk_i.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/issue_stage_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush_i,
    input logic                   dispatch_ready_i,
    input logic                   in_ready_i,
    input rename_pkg::lane_mask_t issue_valid_i,
    input rename_pkg::lane_mask_t writes_rd_i,
    input rename_pkg::phys_reg_t  rd_phys0_i,
    input rename_pkg::phys_reg_t  rd_phys1_i
);

    // Failed assertions, read by the testbench for its verdict
    int assert_fails = 0;

    // ======================================================================
    // Handshake rules
    // ======================================================================

    // Flush blocks acceptance in the same cycle
    flush_blocks_ready: assert property (@(posedge clk) disable iff (!reset)
        flush_i |-> !in_ready_i)
    else begin
        assert_fails++;
        $error("in_ready_o high during flush");
    end

    // Back-pressure freezes the lane valids
    valid_held: assert property (@(posedge clk) disable iff (!reset)
        (!dispatch_ready_i && !flush_i) |=> $stable(issue_valid_i))
    else begin
        assert_fails++;
        $error("issue_valid_o changed under back-pressure");
    end

    // ======================================================================
    // Destination allocation rules
    // ======================================================================

    // x0 is never handed out as a new destination
    rd0_nonzero: assert property (@(posedge clk) disable iff (!reset)
        writes_rd_i[0] |-> (rd_phys0_i != '0))
    else begin
        assert_fails++;
        $error("lane 0 writes with rd_phys zero");
    end

    rd1_nonzero: assert property (@(posedge clk) disable iff (!reset)
        writes_rd_i[1] |-> (rd_phys1_i != '0))
    else begin
        assert_fails++;
        $error("lane 1 writes with rd_phys zero");
    end

    // Two writers in one bundle get distinct registers
    rd_distinct: assert property (@(posedge clk) disable iff (!reset)
        (&writes_rd_i) |-> (rd_phys0_i != rd_phys1_i))
    else begin
        assert_fails++;
        $error("both lanes share one rd_phys");
    end

endmodule

bind issue_stage issue_stage_checker chk_i (
    .clk(clk), .reset(reset),
    .flush_i(flush_i), .dispatch_ready_i(dispatch_ready_i),
    .in_ready_i(in_ready_o), .issue_valid_i(issue_valid_o),
    .writes_rd_i(writes_rd_o),
    .rd_phys0_i(rd_phys0_o), .rd_phys1_i(rd_phys1_o)
);

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage #(
    parameter int PHYS_REGS = 64
) (
    input  logic                   clk,
    input  logic                   reset,
    // Fetch side
    input  rename_pkg::lane_mask_t in_valid_i,
    input  rename_pkg::instr_t     instr0_i,
    input  rename_pkg::instr_t     instr1_i,
    input  rename_pkg::addr_t      pc0_i,
    input  rename_pkg::addr_t      pc1_i,
    output logic                   in_ready_o,
    input  logic                   flush_i,
    // ROB retire returns
    input  rename_pkg::lane_mask_t commit_valid_i,
    input  rename_pkg::phys_reg_t  commit_phys0_i,
    input  rename_pkg::phys_reg_t  commit_phys1_i,
    // Dispatch side
    input  logic                   dispatch_ready_i,
    output rename_pkg::lane_mask_t issue_valid_o,
    output rename_pkg::addr_t      issue_pc0_o,
    output rename_pkg::addr_t      issue_pc1_o,
    output rename_pkg::phys_reg_t  rs1_phys0_o,
    output rename_pkg::phys_reg_t  rs2_phys0_o,
    output rename_pkg::phys_reg_t  rd_phys0_o,
    output rename_pkg::phys_reg_t  old_rd_phys0_o,
    output rename_pkg::phys_reg_t  rs1_phys1_o,
    output rename_pkg::phys_reg_t  rs2_phys1_o,
    output rename_pkg::phys_reg_t  rd_phys1_o,
    output rename_pkg::phys_reg_t  old_rd_phys1_o,
    output rename_pkg::lane_mask_t writes_rd_o
);

    rename_req_if req0_if ();
    rename_req_if req1_if ();
    rename_res_if res0_if ();
    rename_res_if res1_if ();

    rename_pkg::phys_reg_t            alloc0;
    rename_pkg::phys_reg_t            alloc1;
    logic [rename_pkg::PHYS_ADDR_W:0] free_count;
    rename_pkg::lane_mask_t           want;
    logic                             accept;
    logic                             load_en;

    // ======================================================================
    // Decode
    // ======================================================================
    inst_field_decoder dec0_i (.instr_i(instr0_i), .valid_i(in_valid_i[0]), .req_o(req0_if));
    inst_field_decoder dec1_i (.instr_i(instr1_i), .valid_i(in_valid_i[1]), .req_o(req1_if));

    // Lanes that need a fresh physical register
    assign want = {req1_if.writes_rd, req0_if.writes_rd};

    // ======================================================================
    // Rename datapath
    // ======================================================================
    map_table #(.PHYS_REGS(PHYS_REGS)) map_i (
        .clk(clk), .reset(reset),
        .req0_i(req0_if), .req1_i(req1_if),
        .alloc0_i(alloc0), .alloc1_i(alloc1),
        .accept_i(accept),
        .res0_o(res0_if), .res1_o(res1_if)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) free_i (
        .clk(clk), .reset(reset),
        .want_i(want), .accept_i(accept),
        .alloc0_o(alloc0), .alloc1_o(alloc1),
        .free_count_o(free_count),
        .commit_valid_i(commit_valid_i),
        .commit_phys0_i(commit_phys0_i), .commit_phys1_i(commit_phys1_i)
    );

    // ======================================================================
    // Handshake and output register
    // ======================================================================
    issue_control ctrl_i (
        .in_valid_i(in_valid_i), .flush_i(flush_i),
        .dispatch_ready_i(dispatch_ready_i), .free_count_i(free_count),
        .in_ready_o(in_ready_o), .accept_o(accept), .load_en_o(load_en)
    );

    issue_register out_i (
        .clk(clk), .reset(reset),
        .load_en_i(load_en), .accept_i(accept), .flush_i(flush_i),
        .req0_i(req0_if), .req1_i(req1_if), .res0_i(res0_if), .res1_i(res1_if),
        .pc0_i(pc0_i), .pc1_i(pc1_i),
        .issue_valid_o(issue_valid_o), .issue_pc0_o(issue_pc0_o), .issue_pc1_o(issue_pc1_o),
        .rs1_phys0_o(rs1_phys0_o), .rs2_phys0_o(rs2_phys0_o),
        .rd_phys0_o(rd_phys0_o), .old_rd_phys0_o(old_rd_phys0_o),
        .rs1_phys1_o(rs1_phys1_o), .rs2_phys1_o(rs2_phys1_o),
        .rd_phys1_o(rd_phys1_o), .old_rd_phys1_o(old_rd_phys1_o),
        .writes_rd_o(writes_rd_o)
    );

endmodule

`default_nettype wire

// ==== verilog/issue_register.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_register (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_en_i,
    input  logic                   accept_i,
    input  logic                   flush_i,
    rename_req_if.sink             req0_i,
    rename_req_if.sink             req1_i,
    rename_res_if.sink             res0_i,
    rename_res_if.sink             res1_i,
    input  rename_pkg::addr_t      pc0_i,
    input  rename_pkg::addr_t      pc1_i,
    output rename_pkg::lane_mask_t issue_valid_o,
    output rename_pkg::addr_t      issue_pc0_o,
    output rename_pkg::addr_t      issue_pc1_o,
    output rename_pkg::phys_reg_t  rs1_phys0_o,
    output rename_pkg::phys_reg_t  rs2_phys0_o,
    output rename_pkg::phys_reg_t  rd_phys0_o,
    output rename_pkg::phys_reg_t  old_rd_phys0_o,
    output rename_pkg::phys_reg_t  rs1_phys1_o,
    output rename_pkg::phys_reg_t  rs2_phys1_o,
    output rename_pkg::phys_reg_t  rd_phys1_o,
    output rename_pkg::phys_reg_t  old_rd_phys1_o,
    output rename_pkg::lane_mask_t writes_rd_o
);

    // ======================================================================
    // Lane control bits
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid_o <= '0;
            writes_rd_o   <= '0;
        end else if (flush_i) begin
            issue_valid_o <= '0;
            writes_rd_o   <= '0;
        end else if (load_en_i) begin
            // Nothing accepted leaves a bubble in front of dispatch
            issue_valid_o <= accept_i ? {req1_i.valid, req0_i.valid} : '0;
            writes_rd_o   <= accept_i ? {req1_i.writes_rd, req0_i.writes_rd} : '0;
        end
    end

    // ======================================================================
    // Renamed payload
    // ======================================================================

    // Held under back-pressure, qualified by issue_valid_o downstream
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_pc0_o    <= '0;
            issue_pc1_o    <= '0;
            rs1_phys0_o    <= '0;
            rs2_phys0_o    <= '0;
            rd_phys0_o     <= '0;
            old_rd_phys0_o <= '0;
            rs1_phys1_o    <= '0;
            rs2_phys1_o    <= '0;
            rd_phys1_o     <= '0;
            old_rd_phys1_o <= '0;
        end else if (load_en_i) begin
            issue_pc0_o    <= pc0_i;
            issue_pc1_o    <= pc1_i;
            rs1_phys0_o    <= res0_i.rs1_phys;
            rs2_phys0_o    <= res0_i.rs2_phys;
            rd_phys0_o     <= res0_i.rd_phys;
            old_rd_phys0_o <= res0_i.old_rd_phys;
            rs1_phys1_o    <= res1_i.rs1_phys;
            rs2_phys1_o    <= res1_i.rs2_phys;
            rd_phys1_o     <= res1_i.rd_phys;
            old_rd_phys1_o <= res1_i.old_rd_phys;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_control (
    input  rename_pkg::lane_mask_t           in_valid_i,
    input  logic                             flush_i,
    input  logic                             dispatch_ready_i,
    input  logic [rename_pkg::PHYS_ADDR_W:0] free_count_i,
    output logic                             in_ready_o,
    output logic                             accept_o,
    output logic                             load_en_o
);

    logic regs_avail;

    // ======================================================================
    // Input side
    // ======================================================================

    // Two free entries cover the worst case of both lanes writing
    assign regs_avail = (free_count_i >= 2);

    // Whole-bundle ready, no partial acceptance
    assign in_ready_o = dispatch_ready_i && regs_avail && !flush_i;

    // An all-idle bundle is not an acceptance and renames nothing
    assign accept_o = in_ready_o && (in_valid_i != '0);

    // ======================================================================
    // Output side
    // ======================================================================

    // Output register moves whenever dispatch takes its content
    // Flush overrides the load and empties the stage
    assign load_en_o = dispatch_ready_i && !flush_i;

endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list #(
    parameter int PHYS_REGS = 64
) (
    input  logic                               clk,
    input  logic                               reset,
    input  rename_pkg::lane_mask_t             want_i,
    input  logic                               accept_i,
    output rename_pkg::phys_reg_t              alloc0_o,
    output rename_pkg::phys_reg_t              alloc1_o,
    output logic [rename_pkg::PHYS_ADDR_W:0]   free_count_o,
    input  rename_pkg::lane_mask_t             commit_valid_i,
    input  rename_pkg::phys_reg_t              commit_phys0_i,
    input  rename_pkg::phys_reg_t              commit_phys1_i
);

    localparam int INIT_FREE = PHYS_REGS - rename_pkg::ARCH_REGS;

    typedef logic [rename_pkg::PHYS_ADDR_W-1:0] idx_t;
    typedef logic [rename_pkg::PHYS_ADDR_W:0]   count_t;

    rename_pkg::phys_reg_t entries [PHYS_REGS];
    idx_t                  head;
    idx_t                  tail;
    count_t                count;
    logic [1:0]            pop_num;
    logic [1:0]            push_num;

    // Step a queue index forward by n slots, wrapping at PHYS_REGS
    function automatic idx_t advance(input idx_t idx, input logic [1:0] n);
        idx_t r;
        r = idx;
        for (int s = 0; s < 2; s++) begin
            if (s < n) begin
                r = (r == idx_t'(PHYS_REGS - 1)) ? '0 : r + 1'b1;
            end
        end
        return r;
    endfunction

    // ======================================================================
    // Allocation
    // ======================================================================

    // Lane 1 takes the second entry only when lane 0 also writes
    assign alloc0_o = entries[head];
    assign alloc1_o = want_i[0] ? entries[advance(head, 2'd1)] : entries[head];

    assign pop_num  = accept_i ? {1'b0, want_i[0]} + {1'b0, want_i[1]} : 2'd0;
    assign push_num = {1'b0, commit_valid_i[0]} + {1'b0, commit_valid_i[1]};

    assign free_count_o = count;

    // ======================================================================
    // Queue state
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Everything above the architectural set starts free, ascending
            for (int k = 0; k < PHYS_REGS; k++) begin
                entries[k] <= (k < INIT_FREE) ?
                              rename_pkg::phys_reg_t'(rename_pkg::ARCH_REGS + k) : '0;
            end
            head  <= '0;
            tail  <= idx_t'(INIT_FREE);
            count <= count_t'(INIT_FREE);
        end else begin
            // Commit returns land at the tail, lane 0 first
            if (commit_valid_i[0]) begin
                entries[tail] <= commit_phys0_i;
            end
            if (commit_valid_i[1]) begin
                entries[advance(tail, {1'b0, commit_valid_i[0]})] <= commit_phys1_i;
            end
            head  <= advance(head, pop_num);
            tail  <= advance(tail, push_num);
            count <= count - count_t'(pop_num) + count_t'(push_num);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_table #(
    parameter int PHYS_REGS = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    rename_req_if.sink            req0_i,
    rename_req_if.sink            req1_i,
    input  rename_pkg::phys_reg_t alloc0_i,
    input  rename_pkg::phys_reg_t alloc1_i,
    input  logic                  accept_i,
    rename_res_if.source          res0_o,
    rename_res_if.source          res1_o
);

    // Identity reset needs a spare register beyond the architectural set
    if (PHYS_REGS <= rename_pkg::ARCH_REGS + 1 ||
        PHYS_REGS > 2 ** rename_pkg::PHYS_ADDR_W) begin : g_bad_size
        $error("map_table: PHYS_REGS out of range");
    end

    rename_pkg::phys_reg_t map_q [rename_pkg::ARCH_REGS];

    logic fwd_rs1;
    logic fwd_rs2;
    logic same_rd;

    // ======================================================================
    // Lookup
    // ======================================================================

    // Entry 0 is never written, so x0 keeps physical 0
    assign res0_o.rs1_phys    = map_q[req0_i.rs1];
    assign res0_o.rs2_phys    = map_q[req0_i.rs2];
    assign res0_o.rd_phys     = req0_i.writes_rd ? alloc0_i : '0;
    assign res0_o.old_rd_phys = req0_i.writes_rd ? map_q[req0_i.rd] : '0;

    // Lane 1 sees lane 0's new rd inside the same bundle
    // rd of a writing lane is never x0, so x0 sources never forward
    assign fwd_rs1 = req0_i.writes_rd && (req1_i.rs1 == req0_i.rd);
    assign fwd_rs2 = req0_i.writes_rd && (req1_i.rs2 == req0_i.rd);
    assign same_rd = req0_i.writes_rd && (req1_i.rd == req0_i.rd);

    assign res1_o.rs1_phys = fwd_rs1 ? alloc0_i : map_q[req1_i.rs1];
    assign res1_o.rs2_phys = fwd_rs2 ? alloc0_i : map_q[req1_i.rs2];
    assign res1_o.rd_phys  = req1_i.writes_rd ? alloc1_i : '0;

    // WAW in one bundle chains lane 1's old mapping to lane 0's new one
    always_comb begin
        if (!req1_i.writes_rd) begin
            res1_o.old_rd_phys = '0;
        end else if (same_rd) begin
            res1_o.old_rd_phys = alloc0_i;
        end else begin
            res1_o.old_rd_phys = map_q[req1_i.rd];
        end
    end

    // ======================================================================
    // Update
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (accept_i) begin
            if (req0_i.writes_rd) begin
                map_q[req0_i.rd] <= alloc0_i;
            end
            // Lane order, so lane 1 wins on the same rd
            if (req1_i.writes_rd) begin
                map_q[req1_i.rd] <= alloc1_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_field_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_field_decoder (
    input  rename_pkg::instr_t instr_i,
    input  logic               valid_i,
    rename_req_if.source       req_o
);

    logic [6:0]            opcode;
    rename_pkg::arch_reg_t rd;
    logic                  write_class;

    // ======================================================================
    // Field extraction
    // ======================================================================

    // RV32I keeps the register fields at fixed positions in every format
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];

    assign req_o.valid = valid_i;
    assign req_o.rs1   = instr_i[19:15];
    assign req_o.rs2   = instr_i[24:20];
    assign req_o.rd    = rd;

    // ======================================================================
    // Destination write decision
    // ======================================================================

    // Stores, branches, fences and system ops never write rd
    assign write_class = opcode inside {
        rename_pkg::OPC_OP,
        rename_pkg::OPC_OP_IMM,
        rename_pkg::OPC_LOAD,
        rename_pkg::OPC_LUI,
        rename_pkg::OPC_AUIPC,
        rename_pkg::OPC_JAL,
        rename_pkg::OPC_JALR
    };

    // x0 as destination is a discard, so no register is taken for it
    // An idle lane never allocates either
    assign req_o.writes_rd = valid_i && write_class && (rd != '0);

endmodule

`default_nettype wire

// ==== verilog/rename_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decoded register fields of one lane, on the way to rename
interface rename_req_if;
    logic                  valid;
    rename_pkg::arch_reg_t rs1;
    rename_pkg::arch_reg_t rs2;
    rename_pkg::arch_reg_t rd;
    // Set only for a valid lane that writes a non-zero rd
    logic                  writes_rd;

    modport source (
        output valid, rs1, rs2, rd, writes_rd
    );

    modport sink (
        input valid, rs1, rs2, rd, writes_rd
    );
endinterface

// Renamed physical numbers of one lane
interface rename_res_if;
    rename_pkg::phys_reg_t rs1_phys;
    rename_pkg::phys_reg_t rs2_phys;
    rename_pkg::phys_reg_t rd_phys;
    // Previous mapping of rd, freed by the ROB when this lane retires
    rename_pkg::phys_reg_t old_rd_phys;

    modport source (
        output rs1_phys, rs2_phys, rd_phys, old_rd_phys
    );

    modport sink (
        input rs1_phys, rs2_phys, rd_phys, old_rd_phys
    );
endinterface

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // ======================================================================
    // Machine sizes
    // ======================================================================
    localparam int NUM_LANES   = 2;
    localparam int ARCH_REGS   = 32;
    // Wide enough for up to 64 physical registers
    localparam int PHYS_ADDR_W = 6;

    // ======================================================================
    // Types with a meaning
    // ======================================================================
    typedef logic [31:0]            instr_t;
    typedef logic [31:0]            addr_t;
    typedef logic [4:0]             arch_reg_t;
    typedef logic [PHYS_ADDR_W-1:0] phys_reg_t;
    // One bit per lane, bit 0 is lane 0
    typedef logic [NUM_LANES-1:0]   lane_mask_t;

    // ======================================================================
    // RV32I opcodes of the rd-writing classes
    // ======================================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire
